/* verilog/dio_cmd_pkg.sv */
// data channel command set
// command bytes sent by the I/O controller at the start of each SPI frame,
// plus the byte positions of the fields picked out of a directory entry
`default_nettype none

package dio_cmd_pkg;

	// file transfer commands
	localparam logic [7:0] DIO_FILE_TX       = 8'h53;
	localparam logic [7:0] DIO_FILE_TX_DAT   = 8'h54;
	localparam logic [7:0] DIO_FILE_INDEX    = 8'h55;
	localparam logic [7:0] DIO_FILE_INFO     = 8'h56;
	localparam logic [7:0] DIO_FILE_RX       = 8'h57;
	localparam logic [7:0] DIO_FILE_RX_DAT   = 8'h58;

	// IDE bridge commands
	localparam logic [7:0] CMD_IDE_REGS_RD   = 8'h80;
	localparam logic [7:0] CMD_IDE_REGS_WR   = 8'h90;
	localparam logic [7:0] CMD_IDE_DATA_WR   = 8'hA0;
	localparam logic [7:0] CMD_IDE_DATA_RD   = 8'hB0;
	localparam logic [7:0] CMD_IDE_CDDA_RD   = 8'hC0;
	localparam logic [7:0] CMD_IDE_CDDA_WR   = 8'hD0;
	localparam logic [7:0] CMD_IDE_STATUS_WR = 8'hF0;
	localparam logic [7:0] CMD_IDE_CFG_WR    = 8'hFA;

	// directory entry layout
	// extension is three bytes, most significant first
	localparam logic [6:0] INFO_EXT_FIRST    = 7'd8;
	// size is four bytes, least significant first
	localparam logic [6:0] INFO_SIZE_FIRST   = 7'd28;

endpackage

`default_nettype wire

/* verilog/dio_bus_pkg.sv */
// data channel bus widths
// sizes of the SPI byte path, the in-frame byte counter
// and the disk-side word and register address
`default_nettype none

package dio_bus_pkg;

	// one SPI byte
	localparam int DIO_BYTE_W = 8;

	// byte position after the command byte
	localparam int DIO_CNT_W  = 7;

	// IDE data word and task file register address
	localparam int HDD_WORD_W = 16;
	localparam int HDD_ADDR_W = 3;

endpackage

`default_nettype wire

/* verilog/spi_cmd_receiver.sv */
// SPI command receiver
// frames the serial input into a command byte followed by data bytes,
// and strobes each data byte together with its position in the frame
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_receiver
	import dio_bus_pkg::*;
(
	input  logic                  SPI_SCK,
	input  logic                  SPI_SS2,
	input  logic                  SPI_DI,
	output logic [DIO_BYTE_W-1:0] cmd,
	output logic [DIO_BYTE_W-1:0] byte_data,
	output logic [DIO_CNT_W-1:0]  byte_idx,
	output logic                  byte_valid,
	output logic                  bit_last
);

	// 0..7 for the command, then 8..15 for every data byte
	logic [3:0]            bit_cnt;
	logic [DIO_BYTE_W-2:0] sbuf;
	logic [DIO_BYTE_W-1:0] rx_byte;

	// the eighth bit is taken straight from the wire
	assign rx_byte  = {sbuf, SPI_DI};
	assign bit_last = (bit_cnt[2:0] == 3'd7);

	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			bit_cnt    <= 4'd0;
			byte_valid <= 1'b0;
			byte_idx   <= '0;
		end else begin
			byte_valid <= (bit_cnt == 4'd15);

			if (bit_cnt != 4'd15)
				bit_cnt <= bit_cnt + 4'd1;
			else
				bit_cnt <= 4'd8;

			// advance once the current strobe has been seen
			if (byte_valid) begin
				if (~&byte_idx)
					byte_idx <= byte_idx + DIO_CNT_W'(1);
				else
					byte_idx[0] <= ~byte_idx[0];
			end
		end
	end

	always_ff @(posedge SPI_SCK) begin
		sbuf <= {sbuf[DIO_BYTE_W-3:0], SPI_DI};

		if (bit_cnt == 4'd7)
			cmd <= rx_byte;

		if (bit_cnt == 4'd15)
			byte_data <= rx_byte;
	end

	// consecutive data bytes are always eight clocks apart
	a_valid_single: assert property (
		@(posedge SPI_SCK) disable iff (SPI_SS2)
		byte_valid |=> !byte_valid
	);

endmodule

`default_nettype wire

/* verilog/spi_transmitter.sv */
// SPI transmitter
// shifts the status byte out during the command byte, then one readback
// byte per data byte for the read commands; releases SPI_DO otherwise
`timescale 1ns/1ps
`default_nettype none

module spi_transmitter
	import dio_cmd_pkg::*;
	import dio_bus_pkg::*;
(
	input  logic                  SPI_SCK,
	input  logic                  SPI_SS2,
	input  logic [DIO_BYTE_W-1:0] cmd,
	input  logic                  bit_last,
	input  logic [DIO_BYTE_W-1:0] ioctl_din,
	input  logic [HDD_WORD_W-1:0] hdd_data_in,
	input  logic                  hdd_cdda_req,
	input  logic                  hdd_cmd_req,
	input  logic                  hdd_dat_req,
	output wire                   SPI_DO,
	output logic                  din_taken
);

	logic [DIO_BYTE_W-1:0] shift_q;
	logic [DIO_BYTE_W-1:0] status;
	logic [DIO_BYTE_W-1:0] load_byte;
	logic                  load_ok;
	logic                  oe;
	logic                  started;
	// set on the falling edge after the last bit of a byte went out
	logic                  last_q;
	logic [DIO_CNT_W-1:0]  tx_idx;

	assign status = {4'b0000, hdd_dat_req, hdd_cmd_req, 2'b00};
	assign SPI_DO = oe ? shift_q[DIO_BYTE_W-1] : 1'bz;

	// readback source for the next data byte
	always_comb begin
		load_byte = '0;
		load_ok   = 1'b1;
		case (cmd)
			DIO_FILE_RX_DAT:
				load_byte = ioctl_din;
			CMD_IDE_REGS_RD,
			CMD_IDE_DATA_RD:
				// high byte first
				load_byte = tx_idx[0] ? hdd_data_in[7:0] : hdd_data_in[15:8];
			CMD_IDE_CDDA_RD:
				load_byte = DIO_BYTE_W'(hdd_cdda_req);
			default:
				load_ok = 1'b0;
		endcase
	end

	always_ff @(negedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			started   <= 1'b0;
			oe        <= 1'b0;
			last_q    <= 1'b0;
			din_taken <= 1'b0;
			tx_idx    <= '0;
		end else begin
			started   <= 1'b1;
			last_q    <= bit_last;
			din_taken <= last_q && (cmd == DIO_FILE_RX_DAT);
			if (!started) begin
				oe <= 1'b1;
			end else if (last_q) begin
				oe <= load_ok;
				if (~&tx_idx)
					tx_idx <= tx_idx + DIO_CNT_W'(1);
				else
					tx_idx[0] <= ~tx_idx[0];
			end
		end
	end

	always_ff @(negedge SPI_SCK) begin
		if (!started)
			shift_q <= status;
		else if (last_q)
			shift_q <= load_byte;
		else
			shift_q <= shift_q << 1;
	end

endmodule

`default_nettype wire

/* verilog/file_transfer_ctrl.sv */
// file transfer controller
// tracks download and upload sessions, writes downloaded bytes to memory,
// steps the read pointer during uploads and captures the file index,
// extension and size sent by the I/O controller
`timescale 1ns/1ps
`default_nettype none

module file_transfer_ctrl
	import dio_cmd_pkg::*;
	import dio_bus_pkg::*;
#(
	parameter logic [26:0] START_ADDR = 27'd0,
	parameter int          ADDR_W     = 27
) (
	input  logic                  SPI_SCK,
	input  logic                  SPI_SS2,
	input  logic [DIO_BYTE_W-1:0] cmd,
	input  logic [DIO_BYTE_W-1:0] byte_data,
	input  logic [DIO_CNT_W-1:0]  byte_idx,
	input  logic                  byte_valid,
	input  logic                  din_taken,
	output logic                  ioctl_download = 1'b0,
	output logic                  ioctl_upload = 1'b0,
	output logic [DIO_BYTE_W-1:0] ioctl_index = '0,
	output logic                  ioctl_wr,
	output logic [ADDR_W-1:0]     ioctl_addr = '0,
	output logic [DIO_BYTE_W-1:0] ioctl_dout,
	output logic [23:0]           ioctl_fileext = '0,
	output logic [31:0]           ioctl_filesize = '0
);

	localparam logic [ADDR_W-1:0] FIRST_ADDR = ADDR_W'(START_ADDR);

	logic [ADDR_W-1:0] wr_addr = '0;
	logic              dl_byte;

	// a data byte is only written while a download is open
	assign dl_byte = byte_valid && (cmd == DIO_FILE_TX_DAT) && ioctl_download;

	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2)
			ioctl_wr <= 1'b0;
		else
			ioctl_wr <= dl_byte;
	end

	always_ff @(posedge SPI_SCK) begin
		if (dl_byte) begin
			ioctl_dout <= byte_data;
			ioctl_addr <= wr_addr;
			wr_addr    <= wr_addr + ADDR_W'(1);
		end

		// next memory byte once the transmitter has taken the current one
		if (din_taken && ioctl_upload)
			ioctl_addr <= ioctl_addr + ADDR_W'(1);

		if (byte_valid) begin
			case (cmd)
				DIO_FILE_TX: begin
					ioctl_download <= byte_data[0];
					if (byte_data[0])
						wr_addr <= FIRST_ADDR;
				end
				DIO_FILE_RX: begin
					ioctl_upload <= byte_data[0];
					if (byte_data[0])
						ioctl_addr <= FIRST_ADDR;
				end
				DIO_FILE_INDEX:
					ioctl_index <= byte_data;
				DIO_FILE_INFO: begin
					// only the extension and size fields of the entry matter
					case (byte_idx)
						INFO_EXT_FIRST:
							ioctl_fileext[23:16] <= byte_data;
						INFO_EXT_FIRST + 7'd1:
							ioctl_fileext[15:8] <= byte_data;
						INFO_EXT_FIRST + 7'd2:
							ioctl_fileext[7:0] <= byte_data;
						INFO_SIZE_FIRST:
							ioctl_filesize[7:0] <= byte_data;
						INFO_SIZE_FIRST + 7'd1:
							ioctl_filesize[15:8] <= byte_data;
						INFO_SIZE_FIRST + 7'd2:
							ioctl_filesize[23:16] <= byte_data;
						INFO_SIZE_FIRST + 7'd3:
							ioctl_filesize[31:24] <= byte_data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	// writes stop as soon as the stop frame closes the download
	a_wr_in_download: assert property (
		@(posedge SPI_SCK) disable iff (SPI_SS2)
		ioctl_wr |-> ioctl_download
	);

endmodule

`default_nettype wire

/* verilog/ide_cmd_ctrl.sv */
// IDE command decoder
// turns the IDE bridge commands into register, status and sector data
// strobes for the disk controller, pairing data bytes into 16-bit words
`timescale 1ns/1ps
`default_nettype none

module ide_cmd_ctrl
	import dio_cmd_pkg::*;
	import dio_bus_pkg::*;
(
	input  logic                  SPI_SCK,
	input  logic                  SPI_SS2,
	input  logic [DIO_BYTE_W-1:0] cmd,
	input  logic [DIO_BYTE_W-1:0] byte_data,
	input  logic [DIO_CNT_W-1:0]  byte_idx,
	input  logic                  byte_valid,
	output logic [1:0]            hdd0_ena = 2'b00,
	output logic [1:0]            hdd1_ena = 2'b00,
	output logic [HDD_ADDR_W-1:0] hdd_addr,
	output logic                  hdd_wr,
	output logic                  hdd_status_wr,
	output logic                  hdd_data_wr,
	output logic                  hdd_data_rd,
	output logic                  hdd_cdda_wr,
	output logic [HDD_WORD_W-1:0] hdd_data_out
);

	logic cfg_byte;
	logic stat_byte;
	logic regw_byte;
	logic regr_byte;
	logic dataw_byte;
	logic cdda_byte;
	logic datar_byte;
	logic word_byte;
	// second half of a 16-bit word is next
	logic loword;

	assign cfg_byte   = byte_valid && (cmd == CMD_IDE_CFG_WR) && (byte_idx == 7'd0);
	assign stat_byte  = byte_valid && (cmd == CMD_IDE_STATUS_WR) && (byte_idx == 7'd0);
	// task file registers sit on the even bytes 8 to 18
	assign regw_byte  = byte_valid && (cmd == CMD_IDE_REGS_WR) &&
	                    (byte_idx >= 7'd8) && (byte_idx <= 7'd18) && !byte_idx[0];
	assign regr_byte  = byte_valid && (cmd == CMD_IDE_REGS_RD) &&
	                    (byte_idx >= 7'd6) && !byte_idx[0];
	assign dataw_byte = byte_valid && (cmd == CMD_IDE_DATA_WR) && (byte_idx >= 7'd5);
	assign cdda_byte  = byte_valid && (cmd == CMD_IDE_CDDA_WR) && (byte_idx >= 7'd5);
	assign datar_byte = byte_valid && (cmd == CMD_IDE_DATA_RD) && (byte_idx >= 7'd4);
	assign word_byte  = dataw_byte || cdda_byte;

	always_ff @(posedge SPI_SCK or posedge SPI_SS2) begin
		if (SPI_SS2) begin
			hdd_wr        <= 1'b0;
			hdd_status_wr <= 1'b0;
			hdd_data_wr   <= 1'b0;
			hdd_cdda_wr   <= 1'b0;
			hdd_data_rd   <= 1'b0;
			hdd_addr      <= '0;
			loword        <= 1'b0;
		end else begin
			hdd_wr        <= regw_byte;
			hdd_status_wr <= stat_byte;
			hdd_data_wr   <= dataw_byte && loword;
			hdd_cdda_wr   <= cdda_byte && loword;
			hdd_data_rd   <= datar_byte && loword;

			if (word_byte || datar_byte)
				loword <= ~loword;

			// register writes step the address after their strobe
			if (regr_byte || hdd_wr)
				hdd_addr <= hdd_addr + HDD_ADDR_W'(1);
		end
	end

	always_ff @(posedge SPI_SCK) begin
		if (cfg_byte) begin
			hdd0_ena <= byte_data[1:0];
			hdd1_ena <= byte_data[3:2];
		end

		if (stat_byte || regw_byte)
			hdd_data_out <= HDD_WORD_W'(byte_data);

		// high byte arrives first
		if (word_byte) begin
			if (loword)
				hdd_data_out[7:0] <= byte_data;
			else
				hdd_data_out[15:8] <= byte_data;
		end
	end

	a_no_dual_write: assert property (
		@(posedge SPI_SCK) disable iff (SPI_SS2)
		!(hdd_data_wr && hdd_cdda_wr)
	);

endmodule

`default_nettype wire

/* verilog/data_io_top.sv */
// SPI data channel top level
// ties the command receiver and status/readback transmitter to the
// file transfer and IDE command controllers
`timescale 1ns/1ps
`default_nettype none

module data_io_top
	import dio_bus_pkg::*;
#(
	parameter logic [26:0] START_ADDR = 27'd0,
	parameter int          ADDR_W     = 27
) (
	input  wire                   SPI_SCK,
	input  wire                   SPI_SS2,
	input  wire                   SPI_DI,
	output wire                   SPI_DO,

	// memory side
	output wire                   ioctl_download,
	output wire                   ioctl_upload,
	output wire [DIO_BYTE_W-1:0]  ioctl_index,
	output wire                   ioctl_wr,
	output wire [ADDR_W-1:0]      ioctl_addr,
	output wire [DIO_BYTE_W-1:0]  ioctl_dout,
	input  wire [DIO_BYTE_W-1:0]  ioctl_din,
	output wire [23:0]            ioctl_fileext,
	output wire [31:0]            ioctl_filesize,

	// disk side
	input  wire                   hdd_cmd_req,
	input  wire                   hdd_cdda_req,
	input  wire                   hdd_dat_req,
	output wire                   hdd_cdda_wr,
	output wire                   hdd_status_wr,
	output wire [HDD_ADDR_W-1:0]  hdd_addr,
	output wire                   hdd_wr,
	output wire [HDD_WORD_W-1:0]  hdd_data_out,
	input  wire [HDD_WORD_W-1:0]  hdd_data_in,
	output wire                   hdd_data_rd,
	output wire                   hdd_data_wr,
	output wire [1:0]             hdd0_ena,
	output wire [1:0]             hdd1_ena
);

	wire [DIO_BYTE_W-1:0] cmd;
	wire [DIO_BYTE_W-1:0] byte_data;
	wire [DIO_CNT_W-1:0]  byte_idx;
	wire                  byte_valid;
	wire                  bit_last;
	wire                  din_taken;

	spi_cmd_receiver u_rx (
		.SPI_SCK(SPI_SCK), .SPI_SS2(SPI_SS2), .SPI_DI(SPI_DI),
		.cmd(cmd), .byte_data(byte_data), .byte_idx(byte_idx),
		.byte_valid(byte_valid), .bit_last(bit_last)
	);

	spi_transmitter u_tx (
		.SPI_SCK(SPI_SCK), .SPI_SS2(SPI_SS2), .cmd(cmd), .bit_last(bit_last),
		.ioctl_din(ioctl_din), .hdd_data_in(hdd_data_in), .hdd_cdda_req(hdd_cdda_req),
		.hdd_cmd_req(hdd_cmd_req), .hdd_dat_req(hdd_dat_req),
		.SPI_DO(SPI_DO), .din_taken(din_taken)
	);

	file_transfer_ctrl #(.START_ADDR(START_ADDR), .ADDR_W(ADDR_W)) u_file (
		.SPI_SCK(SPI_SCK), .SPI_SS2(SPI_SS2), .cmd(cmd), .byte_data(byte_data),
		.byte_idx(byte_idx), .byte_valid(byte_valid), .din_taken(din_taken),
		.ioctl_download(ioctl_download), .ioctl_upload(ioctl_upload),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_fileext(ioctl_fileext),
		.ioctl_filesize(ioctl_filesize)
	);

	ide_cmd_ctrl u_ide (
		.SPI_SCK(SPI_SCK), .SPI_SS2(SPI_SS2), .cmd(cmd), .byte_data(byte_data),
		.byte_idx(byte_idx), .byte_valid(byte_valid),
		.hdd0_ena(hdd0_ena), .hdd1_ena(hdd1_ena), .hdd_addr(hdd_addr),
		.hdd_wr(hdd_wr), .hdd_status_wr(hdd_status_wr), .hdd_data_wr(hdd_data_wr),
		.hdd_data_rd(hdd_data_rd), .hdd_cdda_wr(hdd_cdda_wr),
		.hdd_data_out(hdd_data_out)
	);

endmodule

`default_nettype wire

/* verif/tb_data_io.sv */
// testbench for the SPI data channel
// replays command frames from a data file, models the memory and disk
// sides, and checks writes, readback bytes and captured file fields
`timescale 1ns/1ps
`default_nettype none

module tb_data_io;

	localparam logic [26:0] START_ADDR = 27'h100;
	localparam int          ADDR_W     = 27;
	localparam int          STIM_DEPTH = 512;

	// frame kinds in the data file
	localparam logic [7:0] KIND_END   = 8'h00;
	localparam logic [7:0] KIND_DL    = 8'h01;
	localparam logic [7:0] KIND_INDEX = 8'h02;
	localparam logic [7:0] KIND_INFO  = 8'h03;
	localparam logic [7:0] KIND_UL    = 8'h04;
	localparam logic [7:0] KIND_CFG   = 8'h05;
	localparam logic [7:0] KIND_REGW  = 8'h06;
	localparam logic [7:0] KIND_DATW  = 8'h07;
	localparam logic [7:0] KIND_STAT  = 8'h08;
	localparam logic [7:0] KIND_DATR  = 8'h09;

	logic              SPI_SCK;
	logic              SPI_SS2;
	logic              SPI_DI;
	wire               SPI_DO;
	wire               ioctl_download;
	wire               ioctl_upload;
	wire [7:0]         ioctl_index;
	wire               ioctl_wr;
	wire [ADDR_W-1:0]  ioctl_addr;
	wire [7:0]         ioctl_dout;
	wire [7:0]         ioctl_din;
	wire [23:0]        ioctl_fileext;
	wire [31:0]        ioctl_filesize;
	logic              hdd_cmd_req;
	logic              hdd_cdda_req;
	logic              hdd_dat_req;
	wire               hdd_cdda_wr;
	wire               hdd_status_wr;
	wire [2:0]         hdd_addr;
	wire               hdd_wr;
	wire [15:0]        hdd_data_out;
	logic [15:0]       hdd_data_in;
	wire               hdd_data_rd;
	wire               hdd_data_wr;
	wire [1:0]         hdd0_ena;
	wire [1:0]         hdd1_ena;

	logic [7:0]        stim [0:STIM_DEPTH-1];
	logic [7:0]        miso [0:63];
	logic [ADDR_W-1:0] dl_next;
	logic              watch_upload;
	int                frame_errors;
	int                total_errors;
	int                frames_run;
	int                frames_failed;
	int                cycles = 0;
	int                cycle_limit = 0;
	int                rd_pulses;
	int                cdda_pulses;
	logic [ADDR_W-1:0] wr_addr_q [$];
	logic [7:0]        wr_data_q [$];
	logic [2:0]        regw_addr_q [$];
	logic [15:0]       regw_data_q [$];
	logic [15:0]       dataw_q [$];
	logic [15:0]       stat_q [$];

	data_io_top #(.START_ADDR(START_ADDR), .ADDR_W(ADDR_W)) UUT (
		.SPI_SCK(SPI_SCK), .SPI_SS2(SPI_SS2), .SPI_DI(SPI_DI), .SPI_DO(SPI_DO),
		.ioctl_download(ioctl_download), .ioctl_upload(ioctl_upload),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_din(ioctl_din), .ioctl_fileext(ioctl_fileext),
		.ioctl_filesize(ioctl_filesize), .hdd_cmd_req(hdd_cmd_req),
		.hdd_cdda_req(hdd_cdda_req), .hdd_dat_req(hdd_dat_req), .hdd_cdda_wr(hdd_cdda_wr),
		.hdd_status_wr(hdd_status_wr), .hdd_addr(hdd_addr), .hdd_wr(hdd_wr),
		.hdd_data_out(hdd_data_out), .hdd_data_in(hdd_data_in), .hdd_data_rd(hdd_data_rd),
		.hdd_data_wr(hdd_data_wr), .hdd0_ena(hdd0_ena), .hdd1_ena(hdd1_ena)
	);

	// memory model, every byte depends on its address
	assign ioctl_din = ioctl_addr[7:0] ^ 8'h5A;

	always #50 SPI_SCK = ~SPI_SCK;

	always @(posedge SPI_SCK) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout after %0d clock cycles, the frames did not complete", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// strobes are captured half a cycle after the edge that sets them
	always @(negedge SPI_SCK) begin
		if (ioctl_wr === 1'b1) begin
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
		end
		if (hdd_wr === 1'b1) begin
			regw_addr_q.push_back(hdd_addr);
			regw_data_q.push_back(hdd_data_out);
		end
		if (hdd_data_wr === 1'b1)
			dataw_q.push_back(hdd_data_out);
		if (hdd_status_wr === 1'b1)
			stat_q.push_back(hdd_data_out);
		if (hdd_data_rd === 1'b1)
			rd_pulses++;
		if (hdd_cdda_wr === 1'b1)
			cdda_pulses++;
	end

	function automatic int record_len(input int p);
		int n;
		n = stim[p + 2];
		return 4 + n + stim[p + 3 + n];
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED: %s got %h expected %h", name, got, exp);
			frame_errors++;
		end
	endtask

	task automatic compare_count(input string what, input int got, input int exp);
		assert (got == exp) else begin
			$display("wrong number of %s: saw %0d, expected %0d", what, got, exp);
			frame_errors++;
		end
	endtask

	task automatic run_frame(input int p);
		logic [7:0] tag;
		logic [7:0] req;
		int n;
		int m;
		int e;
		int i;
		int k;
		tag = stim[p];
		req = stim[p + 1];
		n = stim[p + 2];
		e = p + 4 + n;
		m = stim[e - 1];
		frame_errors = 0;
		hdd_dat_req = req[0];
		hdd_cmd_req = req[1];
		hdd_cdda_req = req[2];
		if (tag == KIND_DATR)
			hdd_data_in = {stim[e], stim[e + 1]};
		// a download start reloads the write address
		if (tag == KIND_DL && stim[p + 3] == 8'h53 && stim[p + 4][0])
			dl_next = START_ADDR[ADDR_W-1:0];
		watch_upload = (tag == KIND_UL) && (stim[p + 3] == 8'h58);
		wr_addr_q.delete();
		wr_data_q.delete();
		regw_addr_q.delete();
		regw_data_q.delete();
		dataw_q.delete();
		stat_q.delete();
		rd_pulses = 0;
		cdda_pulses = 0;

		// msb first, SPI_DO read on the same rising edge as SPI_DI
		SPI_SS2 = 1'b0;
		for (i = 0; i < n * 8; i++) begin
			SPI_DI = stim[p + 3 + i / 8][7 - i % 8];
			@(posedge SPI_SCK);
			miso[i / 8][7 - i % 8] = SPI_DO;
			#10;
			if (watch_upload)
				compare_value("ioctl_upload", ioctl_upload, 1);
		end
		repeat (2) @(posedge SPI_SCK);
		#10;
		SPI_SS2 = 1'b1;
		watch_upload = 1'b0;

		compare_value("status byte", miso[0], {4'b0000, req[0], req[1], 2'b00});
		case (tag)
			KIND_DL: begin
				compare_value("ioctl_download", ioctl_download, stim[e]);
				compare_count("memory writes", wr_data_q.size(), m - 1);
				for (k = 0; k < m - 1 && k < wr_data_q.size(); k++) begin
					compare_value("ioctl_addr", wr_addr_q[k], dl_next);
					compare_value("ioctl_dout", wr_data_q[k], stim[e + 1 + k]);
					dl_next = dl_next + 1;
				end
			end
			KIND_INDEX:
				compare_value("ioctl_index", ioctl_index, stim[e]);
			KIND_INFO: begin
				compare_value("ioctl_fileext", ioctl_fileext,
					{stim[e], stim[e + 1], stim[e + 2]});
				compare_value("ioctl_filesize", ioctl_filesize,
					{stim[e + 3], stim[e + 4], stim[e + 5], stim[e + 6]});
			end
			KIND_UL: begin
				compare_value("ioctl_upload", ioctl_upload, stim[e]);
				for (k = 0; k < m - 1; k++)
					compare_value("SPI_DO byte", miso[1 + k], stim[e + 1 + k]);
			end
			KIND_CFG: begin
				compare_value("hdd0_ena", hdd0_ena, stim[e]);
				compare_value("hdd1_ena", hdd1_ena, stim[e + 1]);
			end
			KIND_REGW: begin
				compare_count("hdd_wr pulses", regw_data_q.size(), m);
				for (k = 0; k < m && k < regw_data_q.size(); k++) begin
					compare_value("hdd_addr", regw_addr_q[k], k);
					compare_value("hdd_data_out", regw_data_q[k], {8'h00, stim[e + k]});
				end
			end
			KIND_DATW: begin
				compare_count("hdd_data_wr pulses", dataw_q.size(), m / 2);
				for (k = 0; k < m / 2 && k < dataw_q.size(); k++)
					compare_value("hdd_data_out", dataw_q[k],
						{stim[e + 2 * k], stim[e + 2 * k + 1]});
			end
			KIND_STAT: begin
				compare_count("hdd_status_wr pulses", stat_q.size(), 1);
				if (stat_q.size() > 0)
					compare_value("hdd_data_out", stat_q[0], {8'h00, stim[e]});
			end
			KIND_DATR: begin
				compare_count("hdd_data_rd pulses", rd_pulses, stim[e + 2]);
				for (k = 0; k < m - 3; k++)
					compare_value("SPI_DO byte", miso[1 + k], stim[e + 3 + k]);
			end
			default:
				assert (1'b0) else begin
					$display("unknown frame kind %h in the data file", tag);
					frame_errors++;
				end
		endcase
		// no frame in the list carries CD audio data
		compare_count("hdd_cdda_wr pulses", cdda_pulses, 0);

		repeat (3 + $urandom % 4) @(posedge SPI_SCK);
		#10;
		frames_run++;
		total_errors += frame_errors;
		if (frame_errors != 0)
			frames_failed++;
		$display("frame %0d kind %h cmd %h: %s", frames_run, tag, stim[p + 3],
			(frame_errors == 0) ? "pass" : "fail");
	endtask

	initial begin
		int p;
		int total_bytes;
		int frame_count;
		int unsigned seed;
		int unsigned dummy;
		SPI_SCK = 1'b0;
		SPI_SS2 = 1'b1;
		SPI_DI = 1'b0;
		hdd_cmd_req = 1'b0;
		hdd_cdda_req = 1'b0;
		hdd_dat_req = 1'b0;
		hdd_data_in = 16'h0000;
		watch_upload = 1'b0;
		dl_next = '0;
		total_errors = 0;
		frames_run = 0;
		frames_failed = 0;
		seed = 32'hc129a6e8;
		dummy = $urandom(seed);
		$readmemh("verif/dio_input.txt", stim);

		// cycle budget from the total frame length
		p = 0;
		total_bytes = 0;
		frame_count = 0;
		while (p < STIM_DEPTH - 4 && stim[p] !== KIND_END && ^stim[p] !== 1'bx) begin
			total_bytes += stim[p + 2];
			frame_count++;
			p += record_len(p);
		end
		cycle_limit = total_bytes * 10 + frame_count * 16 + 100;
		assert (frame_count > 0 && stim[p] === KIND_END) else begin
			$display("data file is missing, empty or has no end marker");
			total_errors++;
		end

		repeat (3) @(posedge SPI_SCK);
		#10;
		p = 0;
		while (p < STIM_DEPTH - 4 && stim[p] !== KIND_END && ^stim[p] !== 1'bx) begin
			run_frame(p);
			p += record_len(p);
		end

		$display("frames run %0d, passed %0d, failed %0d, check errors %0d",
			frames_run, frames_run - frames_failed, frames_failed, total_errors);
		if (total_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
verilog/dio_cmd_pkg.sv
verilog/dio_bus_pkg.sv
verilog/spi_cmd_receiver.sv
verilog/spi_transmitter.sv
verilog/file_transfer_ctrl.sv
verilog/ide_cmd_ctrl.sv
verilog/data_io_top.sv
verif/tb_data_io.sv

/* verif/dio_input.txt */
// each record holds kind, request bits, byte count, frame bytes, expected count, expected values
// kinds 01 download 02 index 03 info 04 upload 05 cfg 06 reg write 07 data write 08 status 09 data read
// request bits 0 hdd_dat_req 1 hdd_cmd_req 2 hdd_cdda_req and kind 00 ends the list
01 00 02 53 01  01 01
01 00 05 54 11 22 33 44  05 01 11 22 33 44
01 00 05 54 55 66 77 88  05 01 55 66 77 88
01 00 02 53 00  01 00
02 00 02 55 07  01 07
// directory entry with extension ROM and size 21234 hex
03 00 21 56
47 41 4D 45 20 20 20 20  52 4F 4D 20 00 00 00 00
00 00 00 00 00 00 00 00  00 00 00 00 34 12 02 00
07 52 4F 4D 00 02 12 34
04 00 02 57 01  01 01
04 00 07 58 00 00 00 00 00 00  07 01 5A 5B 58 59 5E 5F
04 00 02 57 00  01 00
05 00 02 FA 0E  02 02 03
// task file values sit on the even bytes 8 to 18
06 00 14 90 00 00 00 00 00 00 00 00
A1 EE A2 EE A3 EE A4 EE A5 EE A6
06 A1 A2 A3 A4 A5 A6
07 00 0A A0 00 00 00 00 00 DE AD BE EF  04 DE AD BE EF
08 02 02 F0 5C  01 5C
// the first two expected bytes are the word presented on hdd_data_in
09 03 09 B0 00 00 00 00 00 00 00 00  0B C3 A5 02 C3 A5 C3 A5 C3 A5 C3 A5
00
